// File: logic/channel_pkg.sv
// shared register map and data types for the buffered stream channel
// holds the address and data types, the register addresses and the reject counter width
package channel_pkg;

    // the register port addresses four registers
    typedef logic [1:0] cfg_addr_t;

    // register data and status words are one byte wide
    typedef logic [7:0] cfg_data_t;

    // almost-full threshold, read and write
    localparam cfg_addr_t REG_THRESHOLD = 2'd0;
    // current occupancy, read only
    localparam cfg_addr_t REG_LEVEL = 2'd1;
    // reject count, any write clears it
    localparam cfg_addr_t REG_REJECTS = 2'd2;
    // almost-full in bit 0 and sticky underflow in bit 1, any write clears underflow
    localparam cfg_addr_t REG_STATUS = 2'd3;

    // the reject counter saturates at its all-ones value
    localparam int COUNT_W = 8;

endpackage

// File: logic/circular_ptr.sv
// wrapping slot pointer for the small FIFO
// advances by one per strobe and returns to zero after the last slot
`timescale 1ns/1ns

module circular_ptr #(
    parameter int slots_p = 8
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       add_i,
    output logic [$clog2(slots_p)-1:0] ptr_o
);

    localparam int ptr_w_lp = $clog2(slots_p);

    // index of the last slot, the point where the pointer wraps
    localparam logic [ptr_w_lp-1:0] last_lp = ptr_w_lp'(slots_p - 1);

    logic [ptr_w_lp-1:0] ptr_r;

    // an explicit wrap keeps depths that are not a power of two correct
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_r <= '0;
        end else if (add_i) begin
            if (ptr_r == last_lp) begin
                ptr_r <= '0;
            end else begin
                ptr_r <= ptr_r + 1'b1;
            end
        end
    end

    assign ptr_o = ptr_r;

endmodule

// File: logic/fifo_1r1w_small.sv
// small FIFO on a register array with one write port and one read port
// valid-ready on the input side and valid-yumi on the output side
// reports enqueue, reject and underflow events as one-cycle strobes
`timescale 1ns/1ns

module fifo_1r1w_small #(
    parameter int width_p = 16,
    parameter int els_p   = 8
) (
    input  logic               clk_i,
    input  logic               reset_i,

    input  logic [width_p-1:0] data_i,
    input  logic               v_i,
    output logic               ready_o,

    output logic               v_o,
    output logic [width_p-1:0] data_o,
    input  logic               yumi_i,

    output logic               enq_o,
    output logic               reject_o,
    output logic               underflow_o
);

    localparam int ptr_w_lp = $clog2(els_p);

    // storage array, written at the write pointer and read at the read pointer
    logic [width_p-1:0] storage_r [els_p];

    logic [ptr_w_lp-1:0] rptr, wptr;

    // remembers whether the last pointer move was an enqueue or a dequeue
    logic enq_r, deq_r;

    logic equal_ptrs, empty, full, enq, deq;

    // a producer word is taken whenever it meets a ready slot
    assign enq = v_i & ready_o;

    // a yumi on an empty FIFO must not move the read pointer
    // otherwise the pointers would cross and the contents would be lost
    assign deq = yumi_i & ~empty;

    circular_ptr #(
        .slots_p(els_p)
    ) rptr_inst (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .add_i  (deq),
        .ptr_o  (rptr)
    );

    circular_ptr #(
        .slots_p(els_p)
    ) wptr_inst (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .add_i  (enq),
        .ptr_o  (wptr)
    );

    always_ff @(posedge clk_i) begin
        if (enq) begin
            storage_r[wptr] <= data_i;
        end
    end

    // reset counts as a dequeue so that equal pointers read as empty
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enq_r <= 1'b0;
            deq_r <= 1'b1;
        end else if (enq | deq) begin
            enq_r <= enq;
            deq_r <= deq;
        end
    end

    // with equal pointers only the last operation tells full from empty
    // a full FIFO sees no enqueue and an empty one sees no dequeue
    assign equal_ptrs = (rptr == wptr);
    assign empty      = equal_ptrs & deq_r;
    assign full       = equal_ptrs & enq_r;

    // full drops during reset, so ready is held low explicitly
    assign ready_o = ~full & ~reset_i;
    assign v_o     = ~empty;

    // head word comes straight from storage with no output register
    assign data_o = storage_r[rptr];

    // event strobes for the level monitor
    assign enq_o       = enq;
    assign reject_o    = v_i & full & ~reset_i;
    assign underflow_o = yumi_i & empty & ~reset_i;

endmodule

// File: logic/fifo_level_monitor.sv
// occupancy tracking beside the FIFO
// occupancy counter with almost-full compare, saturating reject counter
// and a sticky underflow flag
`timescale 1ns/1ns

module fifo_level_monitor import channel_pkg::*; #(
    parameter int els_p = 8
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      enq_i,
    input  logic      deq_i,
    input  logic      reject_i,
    input  logic      underflow_i,
    input  cfg_data_t threshold_i,
    input  logic      clear_rejects_i,
    input  logic      clear_underflow_i,
    output cfg_data_t level_o,
    output logic      almost_full_o,
    output cfg_data_t reject_count_o,
    output logic      underflow_flag_o
);

    // occupancy runs from zero to els_p inclusive
    localparam int lvl_w_lp = $clog2(els_p + 1);

    logic [lvl_w_lp-1:0] level_r;
    logic [COUNT_W-1:0]  reject_cnt_r;
    logic                underflow_r;

    // a yumi on an empty FIFO removes nothing, so it must not lower the level
    logic dec;
    assign dec = deq_i & ~underflow_i;

    // an enqueue and a dequeue in the same cycle cancel out
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            level_r <= '0;
        end else if (enq_i & ~dec) begin
            level_r <= level_r + 1'b1;
        end else if (dec & ~enq_i) begin
            level_r <= level_r - 1'b1;
        end
    end

    // clears take priority over a reject in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i | clear_rejects_i) begin
            reject_cnt_r <= '0;
        end else if (reject_i && reject_cnt_r != '1) begin
            reject_cnt_r <= reject_cnt_r + 1'b1;
        end
    end

    // underflow stays set until software clears it
    always_ff @(posedge clk_i) begin
        if (reset_i | clear_underflow_i) begin
            underflow_r <= 1'b0;
        end else if (underflow_i) begin
            underflow_r <= 1'b1;
        end
    end

    assign level_o          = cfg_data_t'(level_r);
    assign almost_full_o    = (level_o >= threshold_i);
    assign reject_count_o   = cfg_data_t'(reject_cnt_r);
    assign underflow_flag_o = underflow_r;

endmodule

// File: logic/channel_config_regs.sv
// configuration and status registers for the channel
// almost-full threshold, write-decoded clear pulses and registered readback
`timescale 1ns/1ns

module channel_config_regs import channel_pkg::*; #(
    parameter int els_p = 8
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      cfg_we_i,
    input  logic      cfg_re_i,
    input  cfg_addr_t cfg_addr_i,
    input  cfg_data_t cfg_wdata_i,
    input  cfg_data_t level_i,
    input  logic      almost_full_i,
    input  cfg_data_t reject_count_i,
    input  logic      underflow_flag_i,
    output cfg_data_t cfg_rdata_o,
    output cfg_data_t threshold_o,
    output logic      clear_rejects_o,
    output logic      clear_underflow_o
);

    cfg_data_t threshold_r;
    cfg_data_t rdata_r;

    // the threshold starts at the full depth so almost-full means full
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            threshold_r <= cfg_data_t'(els_p);
        end else if (cfg_we_i && cfg_addr_i == REG_THRESHOLD) begin
            threshold_r <= cfg_wdata_i;
        end
    end

    // writes to the counter and status addresses only clear
    // the written value itself is ignored
    assign clear_rejects_o   = cfg_we_i & (cfg_addr_i == REG_REJECTS);
    assign clear_underflow_o = cfg_we_i & (cfg_addr_i == REG_STATUS);

    // read data is captured on the strobe and held until the next read
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rdata_r <= '0;
        end else if (cfg_re_i) begin
            case (cfg_addr_i)
                REG_THRESHOLD: rdata_r <= threshold_r;
                REG_LEVEL:     rdata_r <= level_i;
                REG_REJECTS:   rdata_r <= reject_count_i;
                REG_STATUS:    rdata_r <= {6'b0, underflow_flag_i, almost_full_i};
                default:       rdata_r <= '0;
            endcase
        end
    end

    assign cfg_rdata_o = rdata_r;
    assign threshold_o = threshold_r;

endmodule

// File: logic/buffered_channel.sv
// buffered stream channel top level
// FIFO, level monitor and register block wired together
`timescale 1ns/1ns

module buffered_channel import channel_pkg::*; #(
    parameter int width_p = 16,
    parameter int els_p   = 8
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic [width_p-1:0] data_i,
    input  logic               v_i,
    output logic               ready_o,
    output logic               v_o,
    output logic [width_p-1:0] data_o,
    input  logic               yumi_i,
    output logic               almost_full_o,
    input  logic               cfg_we_i,
    input  logic               cfg_re_i,
    input  cfg_addr_t          cfg_addr_i,
    input  cfg_data_t          cfg_wdata_i,
    output cfg_data_t          cfg_rdata_o
);

    // FIFO event strobes toward the monitor
    logic enq, reject, underflow;

    // control from the register block and status back to it
    cfg_data_t threshold, level, reject_count;
    logic      clear_rejects, clear_underflow, underflow_flag;

    fifo_1r1w_small #(
        .width_p(width_p),
        .els_p  (els_p)
    ) fifo_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .data_i     (data_i),
        .v_i        (v_i),
        .ready_o    (ready_o),
        .v_o        (v_o),
        .data_o     (data_o),
        .yumi_i     (yumi_i),
        .enq_o      (enq),
        .reject_o   (reject),
        .underflow_o(underflow)
    );

    // the outside yumi doubles as the monitor's decrement strobe
    fifo_level_monitor #(
        .els_p(els_p)
    ) monitor_inst (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .enq_i            (enq),
        .deq_i            (yumi_i),
        .reject_i         (reject),
        .underflow_i      (underflow),
        .threshold_i      (threshold),
        .clear_rejects_i  (clear_rejects),
        .clear_underflow_i(clear_underflow),
        .level_o          (level),
        .almost_full_o    (almost_full_o),
        .reject_count_o   (reject_count),
        .underflow_flag_o (underflow_flag)
    );

    channel_config_regs #(
        .els_p(els_p)
    ) regs_inst (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .cfg_we_i         (cfg_we_i),
        .cfg_re_i         (cfg_re_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_wdata_i      (cfg_wdata_i),
        .level_i          (level),
        .almost_full_i    (almost_full_o),
        .reject_count_i   (reject_count),
        .underflow_flag_i (underflow_flag),
        .cfg_rdata_o      (cfg_rdata_o),
        .threshold_o      (threshold),
        .clear_rejects_o  (clear_rejects),
        .clear_underflow_o(clear_underflow)
    );

endmodule

// File: bench/buffered_channel_tb.sv
// testbench for the buffered stream channel
// clock, reset, random producer and consumer traffic, queue model and register accesses
`timescale 1ns/1ns

module buffered_channel_tb import channel_pkg::*;;

    localparam int width_lp = 16;
    localparam int els_lp   = 8;

    logic clk_i, reset_i, v_i, ready_o, v_o, yumi_i, almost_full_o, cfg_we_i, cfg_re_i;
    logic [width_lp-1:0] data_i, data_o;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_wdata_i, cfg_rdata_o, rd_value;

    // queue model of accepted words plus the expected register state
    logic [width_lp-1:0] model_q[$];
    cfg_data_t threshold_model, reject_model;
    logic underflow_model;
    integer seed, check_count, error_count, waited;

    buffered_channel #(.width_p(width_lp), .els_p(els_lp)) buffered_channel_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic expect_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s after %0d errors", why, error_count);
        $display("Result: FAILED");
        $finish;
    endtask

    // one clock cycle with the output checks at the falling edge and the model update at the rising edge
    task automatic step();
        bit s_push, s_pop, s_reject, s_under, s_reset, s_we;
        cfg_addr_t s_addr;
        cfg_data_t s_wdata;
        logic [width_lp-1:0] s_data;
        @(negedge clk_i);
        if (reset_i) begin
            expect_true(!ready_o && !v_o && !almost_full_o, "outputs not low during reset");
        end else begin
            expect_true(v_o === (model_q.size() != 0), "v_o disagrees with the model queue");
            expect_true(ready_o === (model_q.size() < els_lp), "ready_o disagrees with the model");
            expect_true(almost_full_o === (model_q.size() >= threshold_model),
                $sformatf("almost_full_o is %b at level %0d", almost_full_o, model_q.size()));
            if (yumi_i && v_o && model_q.size() != 0)
                expect_true(data_o === model_q[0],
                    $sformatf("data_o is %h, expected %h", data_o, model_q[0]));
        end
        s_reset  = reset_i;
        s_push   = v_i && ready_o;
        s_pop    = yumi_i && v_o;
        s_reject = v_i && !ready_o;
        s_under  = yumi_i && !v_o;
        s_data   = data_i;
        s_we     = cfg_we_i;
        s_addr   = cfg_addr_i;
        s_wdata  = cfg_wdata_i;
        @(posedge clk_i);
        if (s_reset) begin
            model_q.delete();
            threshold_model = cfg_data_t'(els_lp);
            reject_model    = '0;
            underflow_model = 1'b0;
        end else begin
            if (s_pop && model_q.size() != 0) void'(model_q.pop_front());
            if (s_push) model_q.push_back(s_data);
            if (s_reject && reject_model != 8'hff) reject_model++;
            if (s_under) underflow_model = 1'b1;
            // a clear in the same cycle as an event wins, so it is applied last
            if (s_we && s_addr == REG_THRESHOLD) threshold_model = s_wdata;
            if (s_we && s_addr == REG_REJECTS) reject_model = '0;
            if (s_we && s_addr == REG_STATUS) underflow_model = 1'b0;
        end
        #2;
    endtask

    function automatic cfg_data_t expected_reg(input cfg_addr_t addr);
        case (addr)
            REG_THRESHOLD: return threshold_model;
            REG_LEVEL:     return cfg_data_t'(model_q.size());
            REG_REJECTS:   return reject_model;
            default:       return {6'b0, underflow_model, model_q.size() >= threshold_model};
        endcase
    endfunction

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t value);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = value;
        step();
        cfg_we_i = 1'b0;
    endtask

    // read data is valid one cycle after the strobe
    task automatic read_reg(input cfg_addr_t addr, output cfg_data_t value);
        cfg_data_t expected;
        expected   = expected_reg(addr);
        cfg_re_i   = 1'b1;
        cfg_addr_i = addr;
        step();
        cfg_re_i = 1'b0;
        value    = cfg_rdata_o;
        expect_true(value === expected,
            $sformatf("register %0d read %h, expected %h", addr, value, expected));
    endtask

    task automatic push_word();
        v_i    = 1'b1;
        data_i = width_lp'($random(seed));
        step();
        v_i = 1'b0;
    endtask

    task automatic drain_fifo();
        int n;
        n = 0;
        while (v_o && n < 4 * els_lp) begin
            yumi_i = 1'b1;
            step();
            n++;
        end
        yumi_i = 1'b0;
        if (v_o) abort_run("the FIFO did not empty while draining");
    endtask

    initial begin
        seed = 32'h793c;
        check_count = 0;
        error_count = 0;
        {reset_i, v_i, yumi_i, cfg_we_i, cfg_re_i} = 5'b10000;
        data_i = '0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        @(posedge clk_i);
        #2;
        repeat (8) step();
        reset_i = 1'b0;

        // reset values of every register
        read_reg(REG_THRESHOLD, rd_value);
        expect_true(rd_value === cfg_data_t'(els_lp), "threshold did not reset to the depth");
        read_reg(REG_LEVEL, rd_value);
        read_reg(REG_REJECTS, rd_value);
        read_reg(REG_STATUS, rd_value);

        // random traffic where pops are issued only while a word is visible
        repeat (300) begin
            v_i    = $random(seed) % 2 != 0;
            data_i = width_lp'($random(seed));
            yumi_i = v_o && ($random(seed) % 2 != 0);
            step();
        end
        v_i = 1'b0;
        yumi_i = 1'b0;
        drain_fifo();

        // fill to full, then hold valid against back-pressure
        write_reg(REG_REJECTS, 8'h00);
        waited = 0;
        while (ready_o && waited < 2 * els_lp) begin
            push_word();
            waited++;
        end
        if (ready_o) abort_run("ready_o never dropped while filling the FIFO");
        v_i = 1'b1;
        repeat (5) begin
            data_i = width_lp'($random(seed));
            step();
        end
        v_i = 1'b0;
        read_reg(REG_REJECTS, rd_value);
        expect_true(rd_value === 8'd5, "reject count is not the number of valid cycles while full");
        write_reg(REG_REJECTS, 8'h5a);
        read_reg(REG_REJECTS, rd_value);
        drain_fifo();

        // level and almost-full against two thresholds
        for (int i = 0; i < 2; i++) begin
            write_reg(REG_THRESHOLD, cfg_data_t'(3 + 3 * i));
            repeat (els_lp) begin
                push_word();
                read_reg(REG_LEVEL, rd_value);
            end
            drain_fifo();
            read_reg(REG_LEVEL, rd_value);
        end
        write_reg(REG_THRESHOLD, cfg_data_t'(els_lp));

        // pop on an empty FIFO sets the sticky flag and leaves the queue empty
        read_reg(REG_STATUS, rd_value);
        yumi_i = 1'b1;
        step();
        yumi_i = 1'b0;
        expect_true(model_q.size() == 0 && !v_o, "pop on an empty FIFO produced a word");
        read_reg(REG_STATUS, rd_value);
        expect_true(rd_value[1] === 1'b1, "underflow flag not set after an empty pop");
        write_reg(REG_STATUS, 8'h00);
        read_reg(REG_STATUS, rd_value);

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: buffered_channel.f
logic/channel_pkg.sv
logic/circular_ptr.sv
logic/fifo_1r1w_small.sv
logic/fifo_level_monitor.sv
logic/channel_config_regs.sv
logic/buffered_channel.sv
bench/buffered_channel_tb.sv
